// File: project.f
+incdir+source
source/render_pkg.sv
source/tile_render.sv
source/dram_arbiter.sv
source/line_buffer.sv
source/layer_render_top.sv
tests/layer_render_asserts.sv
tests/layer_render_tb.sv

// File: tests/layer_render_tb.sv
// the DRAM model holds 1024 words, so every command address must stay below 1008
`default_nettype none

`include "render_params.svh"

module layer_render_tb;

    localparam int line_size  = 1 << `RENDER_X_WIDTH;
    localparam int dram_bits  = 10;
    localparam int dram_words = 1 << dram_bits;
    localparam int done_limit = 2000;

    logic                   clk;
    logic                   reset;
    logic                   tile_go;
    logic                   tile_reload;
    render_pkg::x_coord_t   tile_x_coord;
    logic [2:0]             tile_x_size;
    logic                   tile_x_flip;
    render_pkg::dram_addr_t tile_addr;
    render_pkg::palette_t   tile_pal;
    logic                   tile_done;
    logic                   spr_go;
    logic                   spr_reload;
    render_pkg::x_coord_t   spr_x_coord;
    logic [2:0]             spr_x_size;
    logic                   spr_x_flip;
    render_pkg::dram_addr_t spr_addr;
    render_pkg::palette_t   spr_pal;
    logic                   spr_done;
    logic                   dram_req;
    render_pkg::dram_addr_t dram_addr;
    logic                   dram_ready;
    render_pkg::dram_word_t dram_rdata;
    render_pkg::x_coord_t   rd_x;
    render_pkg::lb_data_t   rd_data;

    render_pkg::dram_word_t dram_mem [0:dram_words-1];
    render_pkg::lb_data_t   exp_line [0:line_size-1];
    logic                   exp_mask [0:line_size-1];
    render_pkg::x_coord_t   tile_next;
    render_pkg::x_coord_t   spr_next;
    logic [15:0]            lfsr;
    logic [15:0]            ready_bits;
    logic                   random_ready;
    logic                   compare_busy;
    int                     checks;
    int                     mismatches;
    int                     failures;
    int                     exp_words;
    int                     words_seen;

    layer_render_top uut (.*);

    always #5 clk = ~clk;

    // DRAM answers in the same cycle
    assign dram_rdata = dram_mem[dram_addr[dram_bits-1:0]];

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int count, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits = {bits[14:0], lfsr[15]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // expected entry for pixel k of a word, order 7:4, 3:0, 15:12, 11:8
    function automatic render_pkg::lb_data_t ref_entry(input render_pkg::dram_word_t w,
                                                       input int k,
                                                       input render_pkg::palette_t pal);
        render_pkg::pixel_t p;
        case (k)
            0: p = w[7:4];
            1: p = w[3:0];
            2: p = w[15:12];
            default: p = w[11:8];
        endcase
        return {pal, p};
    endfunction

    task automatic model_render(input int unit, input logic reload, input logic flip,
                                input render_pkg::x_coord_t x, input logic [2:0] size,
                                input render_pkg::dram_addr_t addr,
                                input render_pkg::palette_t pal);
        render_pkg::x_coord_t   pos;
        render_pkg::dram_addr_t word_addr;
        render_pkg::lb_data_t   entry;
        int                     npix;
        npix = 8 * (size + 1);
        exp_words = exp_words + npix / 4;
        if (!reload)
            pos = (unit == 0) ? tile_next : spr_next;
        else if (flip)
            pos = render_pkg::x_coord_t'(x + npix - 1);
        else
            pos = x;
        for (int i = 0; i < npix; i++)
        begin
            word_addr = addr + render_pkg::dram_addr_t'(i / 4);
            entry = ref_entry(dram_mem[word_addr[dram_bits-1:0]], i % 4, pal);
            // transparent pixels leave the old entry
            if (entry[`RENDER_PIX_WIDTH-1:0] != '0)
            begin
                exp_line[pos] = entry;
                exp_mask[pos] = 1'b1;
            end
            pos = flip ? pos - 1'b1 : pos + 1'b1;
        end
        if (unit == 0)
            tile_next = pos;
        else
            spr_next = pos;
    endtask

    task automatic check_value(input string name, input int x,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            mismatches++;
            $display("Mismatch %s x=%0h expected %0h actual %0h", name, x, expected, actual);
        end
    endtask

    task automatic load_command(input int unit, input logic reload, input logic flip,
                                input int x, input int size, input int addr, input int pal);
        render_pkg::x_coord_t   xc;
        logic [2:0]             sz;
        render_pkg::dram_addr_t ad;
        render_pkg::palette_t   pl;
        xc = render_pkg::x_coord_t'(x);
        sz = 3'(size);
        ad = render_pkg::dram_addr_t'(addr);
        pl = render_pkg::palette_t'(pal);
        if (unit == 0)
        begin
            tile_reload  = reload;
            tile_x_flip  = flip;
            tile_x_coord = xc;
            tile_x_size  = sz;
            tile_addr    = ad;
            tile_pal     = pl;
        end
        else
        begin
            spr_reload  = reload;
            spr_x_flip  = flip;
            spr_x_coord = xc;
            spr_x_size  = sz;
            spr_addr    = ad;
            spr_pal     = pl;
        end
        model_render(unit, reload, flip, xc, sz, ad, pl);
    endtask

    task automatic pulse_go(input logic tile, input logic spr);
        tile_go = tile;
        spr_go  = spr;
        @(posedge clk);
        #1;
        tile_go = 1'b0;
        spr_go  = 1'b0;
        // done drops one cycle after go
        if (tile)
            check_value("tile_done", 0, 0, tile_done);
        if (spr)
            check_value("spr_done", 0, 0, spr_done);
    endtask

    task automatic wait_done(input int unit);
        int cycles;
        cycles = 0;
        while (!(unit == 0 ? tile_done : spr_done) && cycles < done_limit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!(unit == 0 ? tile_done : spr_done))
        begin
            failures++;
            $display("%s unit never finished its render", unit == 0 ? "tile" : "sprite");
        end
    endtask

    task automatic render_one(input int unit, input logic reload, input logic flip,
                              input int x, input int size, input int addr, input int pal);
        load_command(unit, reload, flip, x, size, addr, pal);
        pulse_go(unit == 0, unit == 1);
        wait_done(unit);
    endtask

    task automatic run_compare();
        int cycles;
        cycles = 0;
        // every commanded word fetched exactly once
        check_value("dram_req", 0, exp_words, words_seen);
        compare_busy = 1'b1;
        while (compare_busy && cycles < 2 * line_size)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (compare_busy)
        begin
            failures++;
            $display("line buffer readback did not finish in time");
        end
    endtask

    // DRAM accepts about every other cycle in random mode
    always
    begin
        @(posedge clk);
        // a word moves when request and ready meet at the edge
        if (dram_req && dram_ready)
            words_seen++;
        #1;
        if (random_ready)
        begin
            take_bits(1, ready_bits);
            dram_ready = ready_bits[0];
        end
        else
            dram_ready = 1'b1;
    end

    // walks the written entries, read data one cycle after rd_x
    always
    begin
        @(posedge clk);
        if (compare_busy)
        begin
            #1;
            for (int x = 0; x < line_size; x++)
            begin
                if (exp_mask[x])
                begin
                    rd_x = render_pkg::x_coord_t'(x);
                    @(posedge clk);
                    #1;
                    check_value("rd_data", x, exp_line[x], rd_data);
                end
            end
            compare_busy = 1'b0;
        end
    end

    initial
    begin
        logic [15:0]            bits;
        logic [3:0]             nib;
        render_pkg::dram_word_t word;
        clk          = 1'b0;
        reset        = 1'b1;
        tile_go      = 1'b0;
        spr_go       = 1'b0;
        dram_ready   = 1'b1;
        rd_x         = '0;
        random_ready = 1'b0;
        compare_busy = 1'b0;
        checks       = 0;
        mismatches   = 0;
        failures     = 0;
        words_seen   = 0;
        load_command(0, 1'b1, 1'b0, 0, 0, 0, 0);
        load_command(1, 1'b1, 1'b0, 0, 0, 0, 0);
        // units come out of reset at x 0 with nothing fetched
        tile_next    = '0;
        spr_next     = '0;
        exp_words    = 0;
        for (int x = 0; x < line_size; x++)
            exp_mask[x] = 1'b0;

        // random words with roughly one pixel in four transparent
        lfsr = 16'd29954;
        word = '0;
        for (int a = 0; a < dram_words; a++)
        begin
            for (int n = 0; n < 4; n++)
            begin
                take_bits(4, bits);
                nib = bits[3:0];
                take_bits(2, bits);
                if (bits[1:0] == 2'b00)
                    nib = '0;
                word = {word[11:0], nib};
            end
            dram_mem[a] = word;
        end

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // unflipped, every width, overlapping spans
        for (int s = 0; s < 8; s++)
            render_one(0, 1'b1, 1'b0, 20 * s + 3, s, 16 + 20 * s, s + 1);
        run_compare();

        // flipped, two of them wrap past 511
        render_one(0, 1'b1, 1'b1, 100, 0, 300, 9);
        render_one(0, 1'b1, 1'b1, 490, 7, 310, 10);
        render_one(0, 1'b1, 1'b1, 505, 2, 340, 11);
        run_compare();

        // chained in both directions
        render_one(0, 1'b1, 1'b0, 200, 1, 400, 12);
        render_one(0, 1'b0, 1'b0, 0, 2, 420, 13);
        render_one(0, 1'b1, 1'b1, 300, 1, 440, 14);
        render_one(0, 1'b0, 1'b1, 0, 3, 460, 5);
        run_compare();

        // both units at once on disjoint spans
        random_ready = 1'b1;
        load_command(0, 1'b1, 1'b0, 0, 7, 500, 6);
        load_command(1, 1'b1, 1'b1, 256, 5, 600, 7);
        pulse_go(1'b1, 1'b1);
        wait_done(0);
        wait_done(1);
        load_command(0, 1'b1, 1'b0, 128, 3, 700, 8);
        load_command(1, 1'b0, 1'b0, 0, 6, 750, 2);
        pulse_go(1'b1, 1'b1);
        wait_done(0);
        wait_done(1);
        run_compare();

        // sprite over tile
        render_one(0, 1'b1, 1'b0, 400, 3, 800, 3);
        render_one(1, 1'b1, 1'b0, 408, 1, 850, 4);
        run_compare();

        failures = failures + uut.checks.assert_failures;
        $display("checks %0d, mismatches %0d, other failures %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/layer_render_asserts.sv
// bound into layer_render_top to see both units, the arbiter and the line buffer writes at once
`default_nettype none

module layer_render_asserts (
    input wire                         clk,
    input wire                         reset,
    input wire                         tile_req,
    input wire                         spr_req,
    input wire                         tile_ready,
    input wire                         spr_ready,
    input wire                         dram_req,
    input wire render_pkg::dram_addr_t dram_addr,
    input wire                         dram_ready,
    input wire                         tile_we,
    input wire                         spr_we,
    input wire render_pkg::x_coord_t   tile_wx,
    input wire render_pkg::x_coord_t   spr_wx
);

    int assert_failures = 0;

    // each DRAM transfer goes to exactly one unit
    ready_exclusive: assert property (@(posedge clk) disable iff (reset)
        (tile_ready || spr_ready) == (dram_req && dram_ready) && !(tile_ready && spr_ready))
    else
    begin
        $error("DRAM transfer not given to exactly one of tile and sprite units");
        assert_failures = assert_failures + 1;
    end

    // stalled transfer keeps its address
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        dram_req && !dram_ready |=> dram_req && $stable(dram_addr))
    else
    begin
        $error("DRAM address changed while the transfer was stalled");
        assert_failures = assert_failures + 1;
    end

    tile_req_held: assert property (@(posedge clk) disable iff (reset)
        tile_req && !tile_ready |=> tile_req)
    else
    begin
        $error("tile unit dropped its request before it was accepted");
        assert_failures = assert_failures + 1;
    end

    spr_req_held: assert property (@(posedge clk) disable iff (reset)
        spr_req && !spr_ready |=> spr_req)
    else
    begin
        $error("sprite unit dropped its request before it was accepted");
        assert_failures = assert_failures + 1;
    end

    // scenarios keep the two layers apart when they run together
    no_same_x: assert property (@(posedge clk) disable iff (reset)
        !(tile_we && spr_we && (tile_wx == spr_wx)))
    else
    begin
        $error("both units wrote the same line buffer entry in one cycle");
        assert_failures = assert_failures + 1;
    end

endmodule

bind layer_render_top layer_render_asserts checks (
    .clk        (clk),
    .reset      (reset),
    .tile_req   (tile_req),
    .spr_req    (spr_req),
    .tile_ready (tile_ready),
    .spr_ready  (spr_ready),
    .dram_req   (dram_req),
    .dram_addr  (dram_addr),
    .dram_ready (dram_ready),
    .tile_we    (tile_we),
    .spr_we     (spr_we),
    .tile_wx    (tile_wx),
    .spr_wx     (spr_wx)
);

`default_nettype wire

// File: source/layer_render_top.sv
// tile and sprite render units on one DRAM read port; line clear and swap are left to the display side
`default_nettype none

module layer_render_top (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         tile_go,
    input  wire                         tile_reload,
    input  wire render_pkg::x_coord_t   tile_x_coord,
    input  wire [2:0]                   tile_x_size,
    input  wire                         tile_x_flip,
    input  wire render_pkg::dram_addr_t tile_addr,
    input  wire render_pkg::palette_t   tile_pal,
    output wire                         tile_done,
    input  wire                         spr_go,
    input  wire                         spr_reload,
    input  wire render_pkg::x_coord_t   spr_x_coord,
    input  wire [2:0]                   spr_x_size,
    input  wire                         spr_x_flip,
    input  wire render_pkg::dram_addr_t spr_addr,
    input  wire render_pkg::palette_t   spr_pal,
    output wire                         spr_done,
    output wire                         dram_req,
    output render_pkg::dram_addr_t      dram_addr,
    input  wire                         dram_ready,
    input  wire render_pkg::dram_word_t dram_rdata,
    input  wire render_pkg::x_coord_t   rd_x,
    output render_pkg::lb_data_t        rd_data
);

    logic                   tile_req;
    logic                   spr_req;
    logic                   tile_ready;
    logic                   spr_ready;
    render_pkg::dram_addr_t tile_req_addr;
    render_pkg::dram_addr_t spr_req_addr;
    logic                   tile_we;
    logic                   spr_we;
    render_pkg::x_coord_t   tile_wx;
    render_pkg::x_coord_t   spr_wx;
    render_pkg::lb_data_t   tile_wdata;
    render_pkg::lb_data_t   spr_wdata;

    tile_render tile_unit (
        .clk        (clk),
        .reset      (reset),
        .go         (tile_go),
        .reload     (tile_reload),
        .x_flip     (tile_x_flip),
        .x_coord    (tile_x_coord),
        .x_size     (tile_x_size),
        .addr       (tile_addr),
        .pal        (tile_pal),
        .done       (tile_done),
        .dram_req   (tile_req),
        .dram_addr  (tile_req_addr),
        .dram_ready (tile_ready),
        .dram_rdata (dram_rdata),
        .lb_we      (tile_we),
        .lb_x       (tile_wx),
        .lb_data    (tile_wdata)
    );

    tile_render spr_unit (
        .clk        (clk),
        .reset      (reset),
        .go         (spr_go),
        .reload     (spr_reload),
        .x_flip     (spr_x_flip),
        .x_coord    (spr_x_coord),
        .x_size     (spr_x_size),
        .addr       (spr_addr),
        .pal        (spr_pal),
        .done       (spr_done),
        .dram_req   (spr_req),
        .dram_addr  (spr_req_addr),
        .dram_ready (spr_ready),
        .dram_rdata (dram_rdata),
        .lb_we      (spr_we),
        .lb_x       (spr_wx),
        .lb_data    (spr_wdata)
    );

    // rdata goes to both units, only the granted one sees ready
    dram_arbiter arbiter (
        .clk        (clk),
        .reset      (reset),
        .tile_req   (tile_req),
        .spr_req    (spr_req),
        .tile_addr  (tile_req_addr),
        .spr_addr   (spr_req_addr),
        .tile_ready (tile_ready),
        .spr_ready  (spr_ready),
        .dram_req   (dram_req),
        .dram_addr  (dram_addr),
        .dram_ready (dram_ready)
    );

    line_buffer lbuf (
        .clk       (clk),
        .tile_we   (tile_we),
        .spr_we    (spr_we),
        .tile_x    (tile_wx),
        .spr_x     (spr_wx),
        .tile_data (tile_wdata),
        .spr_data  (spr_wdata),
        .rd_x      (rd_x),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

// File: source/line_buffer.sv
// 512-entry pixel line; sprite write wins on an equal address and there is no clear between lines
`default_nettype none

`include "render_params.svh"

module line_buffer (
    input  wire                       clk,
    input  wire                       tile_we,
    input  wire                       spr_we,
    input  wire render_pkg::x_coord_t tile_x,
    input  wire render_pkg::x_coord_t spr_x,
    input  wire render_pkg::lb_data_t tile_data,
    input  wire render_pkg::lb_data_t spr_data,
    input  wire render_pkg::x_coord_t rd_x,
    output render_pkg::lb_data_t      rd_data
);

    localparam int depth = 1 << `RENDER_X_WIDTH;

    render_pkg::lb_data_t mem [0:depth-1];

    logic tile_hit;

    // sprite layer sits on top
    assign tile_hit = tile_we && !(spr_we && (spr_x == tile_x));

    always_ff @(posedge clk)
    begin
        if (tile_hit)
            mem[tile_x] <= tile_data;
        if (spr_we)
            mem[spr_x] <= spr_data;
    end

    // display side read, one cycle latency
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_x];
    end

endmodule

`default_nettype wire

// File: source/dram_arbiter.sv
// round-robin arbiter for two requesters; requesters must hold req and addr until ready
`default_nettype none

module dram_arbiter (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         tile_req,
    input  wire                         spr_req,
    input  wire render_pkg::dram_addr_t tile_addr,
    input  wire render_pkg::dram_addr_t spr_addr,
    output logic                        tile_ready,
    output logic                        spr_ready,
    output logic                        dram_req,
    output render_pkg::dram_addr_t      dram_addr,
    input  wire                         dram_ready
);

    logic last_spr;
    logic hold;
    logic hold_spr;
    logic grant_spr;

    always_comb
    begin
        // stalled transfer keeps its unit
        if (hold)
            grant_spr = hold_spr;
        // on a tie the unit not served last goes first
        else if (tile_req && spr_req)
            grant_spr = !last_spr;
        else
            grant_spr = spr_req;
    end

    assign dram_req   = tile_req || spr_req;
    assign dram_addr  = grant_spr ? spr_addr : tile_addr;
    assign tile_ready = dram_ready && tile_req && !grant_spr;
    assign spr_ready  = dram_ready && spr_req && grant_spr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // tile unit first after reset
            last_spr <= 1'b1;
            hold     <= 1'b0;
        end
        else if (dram_req)
        begin
            if (dram_ready)
            begin
                last_spr <= grant_spr;
                hold     <= 1'b0;
            end
            else
                hold <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dram_req && !dram_ready)
            hold_spr <= grant_spr;
    end

endmodule

`default_nettype wire

// File: source/tile_render.sv
// one layer render unit; go is ignored while busy and the x position wraps modulo 512 without clipping
`default_nettype none

`include "render_params.svh"

module tile_render (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         go,
    input  wire                         reload,
    input  wire                         x_flip,
    input  wire render_pkg::x_coord_t   x_coord,
    input  wire [2:0]                   x_size,
    input  wire render_pkg::dram_addr_t addr,
    input  wire render_pkg::palette_t   pal,
    output logic                        done,
    output logic                        dram_req,
    output render_pkg::dram_addr_t      dram_addr,
    input  wire                         dram_ready,
    input  wire render_pkg::dram_word_t dram_rdata,
    output logic                        lb_we,
    output render_pkg::x_coord_t        lb_x,
    output render_pkg::lb_data_t        lb_data
);

    localparam int lat_width = 3 * `RENDER_PIX_WIDTH;

    render_pkg::render_state_t state;
    logic [4:0]                words_left;
    logic [1:0]                pix_cnt;
    logic [lat_width-1:0]      pix_lat;
    logic                      req_reg;
    logic                      flip_reg;
    logic                      start;
    logic                      accept;
    logic                      wr_step;
    render_pkg::x_coord_t      x_pos;
    render_pkg::x_coord_t      x_start;
    render_pkg::dram_addr_t    addr_reg;
    render_pkg::palette_t      pal_reg;
    render_pkg::pixel_t        pix;

    assign done      = (state == render_pkg::idle);
    assign start     = go && done;
    assign dram_req  = req_reg;
    assign dram_addr = addr_reg;
    assign accept    = req_reg && dram_ready;

    // one pixel slot per cycle, transparent ones included
    assign wr_step = accept || (pix_cnt != 2'd0);
    assign pix     = accept ? dram_rdata[7:4] : pix_lat[lat_width-1 -: `RENDER_PIX_WIDTH];
    assign lb_we   = wr_step && (pix != '0);
    assign lb_x    = x_pos;
    assign lb_data = {pal_reg, pix};

    // flipped span begins at its right edge
    assign x_start = !reload ? x_pos :
                     x_flip  ? x_coord + render_pkg::x_coord_t'({x_size, 3'b111}) :
                               x_coord;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= render_pkg::idle;
            words_left <= '0;
            pix_cnt    <= '0;
            req_reg    <= 1'b0;
            x_pos      <= '0;
        end
        else
        begin
            if (start)
                x_pos <= x_start;
            else if (wr_step)
                x_pos <= flip_reg ? x_pos - 1'b1 : x_pos + 1'b1;

            // latched pixels still to go out
            if (accept)
                pix_cnt <= 2'd3;
            else if (pix_cnt != 2'd0)
                pix_cnt <= pix_cnt - 1'b1;

            case (state)
                render_pkg::idle:
                begin
                    if (start)
                    begin
                        state      <= render_pkg::fetch;
                        words_left <= {1'b0, x_size, 1'b1} + 5'd1;
                        req_reg    <= 1'b1;
                    end
                end
                render_pkg::fetch:
                begin
                    if (accept)
                    begin
                        req_reg    <= 1'b0;
                        words_left <= words_left - 1'b1;
                        if (words_left == 5'd1)
                            state <= render_pkg::drain;
                    end
                    // ask early so the next word lands right after the last latched pixel
                    else if (!req_reg && pix_cnt <= 2'd1)
                        req_reg <= 1'b1;
                end
                render_pkg::drain:
                begin
                    if (pix_cnt == 2'd1)
                        state <= render_pkg::idle;
                end
                default:
                    state <= render_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            pal_reg  <= pal;
            flip_reg <= x_flip;
            addr_reg <= addr;
        end
        else if (accept)
            addr_reg <= addr_reg + 1'b1;

        // keep pixels 2..4 in output order, shift one out per cycle
        if (accept)
            pix_lat <= {dram_rdata[3:0], dram_rdata[15:12], dram_rdata[11:8]};
        else if (pix_cnt != 2'd0)
            pix_lat <= pix_lat << `RENDER_PIX_WIDTH;
    end

endmodule

`default_nettype wire

// File: source/render_pkg.sv
// shared render types; all widths come from render_params.svh and a line buffer entry packs palette over pixel
`default_nettype none

`include "render_params.svh"

package render_pkg;

    // position in the 512-entry line buffer
    typedef logic [`RENDER_X_WIDTH-1:0] x_coord_t;

    typedef logic [`RENDER_ADDR_WIDTH-1:0] dram_addr_t;

    // four pixels per word
    typedef logic [`RENDER_WORD_WIDTH-1:0] dram_word_t;

    // value 0 is transparent
    typedef logic [`RENDER_PIX_WIDTH-1:0] pixel_t;

    typedef logic [`RENDER_PAL_WIDTH-1:0] palette_t;

    // palette in the upper half, pixel in the lower half
    typedef logic [`RENDER_PAL_WIDTH+`RENDER_PIX_WIDTH-1:0] lb_data_t;

    typedef enum logic [1:0]
    {
        idle,
        fetch,
        drain
    } render_state_t;

endpackage

`default_nettype wire

// File: source/render_params.svh
// widths for a 512-pixel line and 4-bit packed pixels; the unpacking order assumes four pixels per word
`ifndef RENDER_PARAMS_SVH
`define RENDER_PARAMS_SVH

// line buffer x position
`define RENDER_X_WIDTH 9

// DRAM word address
`define RENDER_ADDR_WIDTH 21

// DRAM data word, four pixels
`define RENDER_WORD_WIDTH 16

// one packed pixel
`define RENDER_PIX_WIDTH 4

// palette number stored with each pixel
`define RENDER_PAL_WIDTH 4

`endif
